// ==== Makefile ====
TOP = adderStreamTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f vlog.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== source/addPkg.sv ====
package addPkg;

  localparam int SliceWidth = 15;
  localparam int WordWidth  = 2 * SliceWidth;

  // bits count from 1 like the adder core.
  typedef logic [SliceWidth:1] sliceT;

  // two slices side by side, high half on top.
  typedef logic [WordWidth:1] wordT;

endpackage

// ==== source/adderStream.sv ====
module adderStream #(
  parameter creditPkg::creditT QueueDepth = creditPkg::DefaultQueueDepth,
  parameter creditPkg::creditT MaxCredits = creditPkg::DefaultMaxCredits
) (
  input  logic         clk,
  input  logic         rstN,
  input  logic         inValid,
  input  addPkg::wordT inA,
  input  addPkg::wordT inB,
  input  logic         inSub,
  output logic         creditReturn,
  input  logic         outCredit,
  output logic         outValid,
  output addPkg::wordT outSum,
  output logic         outCarry,
  output logic         outOverflow
);

  import addPkg::*;

  logic  issueValid;
  wordT  issueA;
  wordT  issueB;
  logic  issueSub;
  logic  lowValid;
  sliceT lowSum;
  logic  lowCarry;
  sliceT highSum0;
  sliceT highSum1;
  logic  highCarry0;
  logic  highCarry1;
  logic  signA;
  logic  signB;

  operandQueue #(
    .QueueDepth (QueueDepth),
    .MaxCredits (MaxCredits)
  ) queue (
    .clk          (clk),
    .rstN         (rstN),
    .inValid      (inValid),
    .inA          (inA),
    .inB          (inB),
    .inSub        (inSub),
    .outCredit    (outCredit),
    .creditReturn (creditReturn),
    .issueValid   (issueValid),
    .issueA       (issueA),
    .issueB       (issueB),
    .issueSub     (issueSub)
  );

  // both halves see the same issued operands.
  lowHalfStage lowStage (
    .clk        (clk),
    .rstN       (rstN),
    .issueValid (issueValid),
    .issueA     (issueA),
    .issueB     (issueB),
    .issueSub   (issueSub),
    .lowValid   (lowValid),
    .lowSum     (lowSum),
    .lowCarry   (lowCarry)
  );

  highHalfStage highStage (
    .clk        (clk),
    .issueA     (issueA),
    .issueB     (issueB),
    .issueSub   (issueSub),
    .highSum0   (highSum0),
    .highSum1   (highSum1),
    .highCarry0 (highCarry0),
    .highCarry1 (highCarry1),
    .signA      (signA),
    .signB      (signB)
  );

  sumMerge merge (
    .clk         (clk),
    .rstN        (rstN),
    .lowValid    (lowValid),
    .lowSum      (lowSum),
    .lowCarry    (lowCarry),
    .highSum0    (highSum0),
    .highSum1    (highSum1),
    .highCarry0  (highCarry0),
    .highCarry1  (highCarry1),
    .signA       (signA),
    .signB       (signB),
    .outValid    (outValid),
    .outSum      (outSum),
    .outCarry    (outCarry),
    .outOverflow (outOverflow)
  );

endmodule

// ==== source/cla15.sv ====
module cla15 (
  input  addPkg::sliceT a,
  input  addPkg::sliceT b,
  input  logic          cin,
  output addPkg::sliceT sum
);

  import addPkg::*;

  logic [SliceWidth-1:1] g;   // top bit only needs its half sum.
  logic [SliceWidth-1:1] p;
  sliceT                 hs;
  logic                  gs;  // bit 1 generate with carry-in folded in.
  logic [7:1]            g1;
  logic [7:2]            p1;
  logic [3:1]            g2;
  logic [3:2]            p2;
  logic                  g3;
  logic [SliceWidth-1:1] c;   // c[k] is the carry out of bit k.

  assign g  = a[SliceWidth-1:1] & b[SliceWidth-1:1];
  assign p  = a[SliceWidth-1:1] | b[SliceWidth-1:1];
  assign hs = a ^ b;
  assign gs = g[1] | (p[1] & cin);

  // first level merges adjacent bit pairs.
  for (genvar i = 1; i <= 7; i++) begin : pairLevel
    if (i == 1) begin : withCarryIn
      assign g1[i] = g[2] | (p[2] & gs);
    end else begin : plainPair
      assign g1[i] = g[2*i] | (p[2*i] & g[2*i-1]);
      assign p1[i] = p[2*i] & p[2*i-1];
    end
  end

  // groups of four.
  assign g2[1] = g1[2] | (p1[2] & g1[1]);
  assign g2[2] = g1[4] | (p1[4] & g1[3]);
  assign g2[3] = g1[6] | (p1[6] & g1[5]);
  assign p2[2] = p1[4] & p1[3];
  assign p2[3] = p1[6] & p1[5];

  assign g3 = g2[2] | (p2[2] & g2[1]);  // bits 8 down to 1.

  assign c[1]  = gs;
  assign c[2]  = g1[1];
  assign c[3]  = g[3] | (p[3] & c[2]);
  assign c[4]  = g2[1];
  assign c[5]  = g[5] | (p[5] & c[4]);
  assign c[6]  = g1[3] | (p1[3] & c[4]);
  assign c[7]  = g[7] | (p[7] & c[6]);
  assign c[8]  = g3;
  assign c[9]  = g[9] | (p[9] & c[8]);
  assign c[10] = g1[5] | (p1[5] & c[8]);
  assign c[11] = g[11] | (p[11] & c[10]);
  assign c[12] = g2[3] | (p2[3] & c[8]);
  assign c[13] = g[13] | (p[13] & c[12]);
  assign c[14] = g1[7] | (p1[7] & c[12]);

  // each bit takes the carry from the bit below.
  assign sum = hs ^ {c, cin};

endmodule

// ==== source/creditPkg.sv ====
package creditPkg;

  localparam int CreditWidth = 4;

  // held downstream credits.
  typedef logic [CreditWidth-1:0] creditT;

  // upstream starts with one credit per queue entry.
  localparam creditT DefaultQueueDepth = creditT'(4);

  // ceiling on credits granted but not yet spent.
  localparam creditT DefaultMaxCredits = creditT'(8);

endpackage

// ==== source/highHalfStage.sv ====
module highHalfStage (
  input  logic          clk,
  input  addPkg::wordT  issueA,
  input  addPkg::wordT  issueB,
  input  logic          issueSub,
  output addPkg::sliceT highSum0,
  output addPkg::sliceT highSum1,
  output logic          highCarry0,
  output logic          highCarry1,
  output logic          signA,
  output logic          signB
);

  import addPkg::*;

  sliceT      aHigh;
  sliceT      bHigh;
  sliceT      sumSel [2];
  logic [1:0] carrySel;

  assign aHigh = issueA[WordWidth:SliceWidth+1];
  assign bHigh = issueB[WordWidth:SliceWidth+1] ^ {SliceWidth{issueSub}};

  // both outcomes of the low half carry.
  for (genvar k = 0; k < 2; k++) begin : carryIn
    cla15 highAdder (
      .a   (aHigh),
      .b   (bHigh),
      .cin (k == 1),
      .sum (sumSel[k])
    );

    assign carrySel[k] = (aHigh[SliceWidth] & bHigh[SliceWidth]) |
                         ((aHigh[SliceWidth] ^ bHigh[SliceWidth]) & ~sumSel[k][SliceWidth]);
  end

  always_ff @(posedge clk) begin
    highSum0   <= sumSel[0];
    highSum1   <= sumSel[1];
    highCarry0 <= carrySel[0];
    highCarry1 <= carrySel[1];
    signA      <= aHigh[SliceWidth];
    signB      <= bHigh[SliceWidth];  // sign after the inversion.
  end

endmodule

// ==== source/lowHalfStage.sv ====
module lowHalfStage (
  input  logic          clk,
  input  logic          rstN,
  input  logic          issueValid,
  input  addPkg::wordT  issueA,
  input  addPkg::wordT  issueB,
  input  logic          issueSub,
  output logic          lowValid,
  output addPkg::sliceT lowSum,
  output logic          lowCarry
);

  import addPkg::*;

  sliceT aLow;
  sliceT bLow;
  sliceT sumLow;
  logic  carryLow;

  assign aLow = issueA[SliceWidth:1];
  assign bLow = issueB[SliceWidth:1] ^ {SliceWidth{issueSub}};  // inverted B when subtracting.

  cla15 lowAdder (
    .a   (aLow),
    .b   (bLow),
    .cin (issueSub),
    .sum (sumLow)
  );

  // carry into the top bit shows up as its sum flipping.
  assign carryLow = (aLow[SliceWidth] & bLow[SliceWidth]) |
                    ((aLow[SliceWidth] ^ bLow[SliceWidth]) & ~sumLow[SliceWidth]);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      lowValid <= 1'b0;
    end else begin
      lowValid <= issueValid;
    end
  end

  always_ff @(posedge clk) begin
    lowSum   <= sumLow;
    lowCarry <= carryLow;
  end

endmodule

// ==== source/operandQueue.sv ====
module operandQueue #(
  parameter creditPkg::creditT QueueDepth = creditPkg::DefaultQueueDepth,
  parameter creditPkg::creditT MaxCredits = creditPkg::DefaultMaxCredits
) (
  input  logic         clk,
  input  logic         rstN,
  input  logic         inValid,
  input  addPkg::wordT inA,
  input  addPkg::wordT inB,
  input  logic         inSub,
  input  logic         outCredit,
  output logic         creditReturn,
  output logic         issueValid,
  output addPkg::wordT issueA,
  output addPkg::wordT issueB,
  output logic         issueSub
);

  import addPkg::*;
  import creditPkg::*;

  localparam int PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CountWidth = $clog2(QueueDepth + 1);

  wordT                  aMem [QueueDepth];
  wordT                  bMem [QueueDepth];
  logic [QueueDepth-1:0] subMem;
  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0] count;
  creditT                credits;  // downstream credits not yet spent.
  logic                  full;

  assign full       = (count == CountWidth'(QueueDepth));
  assign issueValid = (count != '0) && (credits != '0);
  assign issueA     = aMem[rdPtr];
  assign issueB     = bMem[rdPtr];
  assign issueSub   = subMem[rdPtr];

  always_ff @(posedge clk) begin
    if (inValid) begin
      aMem[wrPtr]   <= inA;
      bMem[wrPtr]   <= inB;
      subMem[wrPtr] <= inSub;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr        <= '0;
      rdPtr        <= '0;
      count        <= '0;
      credits      <= '0;
      creditReturn <= 1'b0;
    end else begin
      if (inValid) begin
        wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (issueValid) begin
        rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      count        <= count + CountWidth'(inValid) - CountWidth'(issueValid);
      credits      <= credits + creditT'(outCredit) - creditT'(issueValid);
      creditReturn <= issueValid;  // freed entry goes back upstream.
    end
  end

  // upstream only sends while it holds a credit.
  assert property (@(posedge clk) disable iff (!rstN) full |-> !inValid);

  assert property (@(posedge clk) disable iff (!rstN) credits <= MaxCredits);

endmodule

// ==== source/sumMerge.sv ====
module sumMerge (
  input  logic          clk,
  input  logic          rstN,
  input  logic          lowValid,
  input  addPkg::sliceT lowSum,
  input  logic          lowCarry,
  input  addPkg::sliceT highSum0,
  input  addPkg::sliceT highSum1,
  input  logic          highCarry0,
  input  logic          highCarry1,
  input  logic          signA,
  input  logic          signB,
  output logic          outValid,
  output addPkg::wordT  outSum,
  output logic          outCarry,
  output logic          outOverflow
);

  import addPkg::*;

  sliceT highSel;
  logic  carrySel;
  wordT  sumNext;
  logic  overflowNext;

  // low carry picks the precomputed high half.
  assign highSel  = lowCarry ? highSum1 : highSum0;
  assign carrySel = lowCarry ? highCarry1 : highCarry0;
  assign sumNext  = {highSel, lowSum};

  // like signs in, other sign out.
  assign overflowNext = (signA == signB) && (highSel[SliceWidth] != signA);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= lowValid;
    end
  end

  always_ff @(posedge clk) begin
    outSum      <= sumNext;
    outCarry    <= carrySel;
    outOverflow <= overflowNext;
  end

  // the carry-in 1 result is the carry-in 0 result plus one.
  assert property (@(posedge clk) disable iff (!rstN)
    lowValid |-> (highSum1 == sliceT'(highSum0 + 1'b1)) &&
                 (highCarry1 == (highCarry0 | (&highSum0))));

endmodule

// ==== tests/adderStreamTb.sv ====
module adderStreamTb;

  timeunit 1ns;
  timeprecision 100ps;

  import creditPkg::*;

  localparam creditT QueueDepth     = DefaultQueueDepth;
  localparam creditT MaxCredits     = DefaultMaxCredits;
  localparam int     RandomOps      = 200;
  localparam int     TotalBeats     = 2 + 5 + 8 + int'(QueueDepth) + RandomOps;
  localparam int     WatchdogCycles = TotalBeats * 20 + 500;
  localparam int     WaitLimit      = 50;

  logic        clk;
  logic        rstN;
  logic        inValid;
  logic [29:0] inA;
  logic [29:0] inB;
  logic        inSub;
  logic        creditReturn;
  logic        outCredit;
  logic        outValid;
  logic [29:0] outSum;
  logic        outCarry;
  logic        outOverflow;

  logic [31:0] expected [$];  // {overflow, carry, sum} in input order.
  int          upCredits;
  int          sent     = 0;
  int          received = 0;
  int          granted  = 0;
  int          returns  = 0;
  int          checks   = 0;
  int          errors   = 0;
  int          seed     = 73491;

  adderStream #(
    .QueueDepth (QueueDepth),
    .MaxCredits (MaxCredits)
  ) UUT (
    .clk          (clk),
    .rstN         (rstN),
    .inValid      (inValid),
    .inA          (inA),
    .inB          (inB),
    .inSub        (inSub),
    .creditReturn (creditReturn),
    .outCredit    (outCredit),
    .outValid     (outValid),
    .outSum       (outSum),
    .outCarry     (outCarry),
    .outOverflow  (outOverflow)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 30-bit two's complement arithmetic rule.
  function automatic logic [31:0] expectedResult(logic [29:0] a, logic [29:0] b, logic sub);
    logic [30:0] full;
    logic        carry;
    longint      sa;
    longint      sb;
    longint      sr;
    sa = a[29] ? longint'(a) - longint'(2**30) : longint'(a);
    sb = b[29] ? longint'(b) - longint'(2**30) : longint'(b);
    if (sub) begin
      full  = {1'b0, a} - {1'b0, b};
      carry = (a >= b);  // set when no borrow.
      sr    = sa - sb;
    end else begin
      full  = {1'b0, a} + {1'b0, b};
      carry = full[30];
      sr    = sa + sb;
    end
    return {(sr > longint'(2**29 - 1)) || (sr < -longint'(2**29)), carry, full[29:0]};
  endfunction

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, want);
      errors++;
    end
  endtask

  // results are popped in order as they leave the DUT.
  always @(posedge clk) begin
    logic [31:0] want;
    if (rstN && creditReturn) begin
      upCredits++;
      returns++;
    end
    if (rstN && outValid) begin
      if (expected.size() == 0) begin
        $display("a result arrived at %0t with no operation outstanding", $time);
        errors++;
      end else begin
        want = expected.pop_front();
        checkEq("sum", 32'(outSum), {2'b00, want[29:0]});
        checkEq("carry", 32'(outCarry), 32'(want[30]));
        checkEq("overflow", 32'(outOverflow), 32'(want[31]));
        received++;
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("watchdog: the run did not finish within %0d cycles", WatchdogCycles);
    $display("Checks failed");
    $finish;
  end

  task automatic driveBeat(input logic [29:0] a, input logic [29:0] b, input logic sub);
    inValid = 1'b1;
    inA     = a;
    inB     = b;
    inSub   = sub;
    expected.push_back(expectedResult(a, b, sub));
    upCredits--;
    sent++;
  endtask

  task automatic sendBeat(input logic [29:0] a, input logic [29:0] b, input logic sub);
    int cycles;
    cycles = 0;
    while (upCredits == 0 && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (upCredits == 0) begin
      $display("no upstream credit came back at %0t, beat not sent", $time);
      errors++;
      return;
    end
    driveBeat(a, b, sub);
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic grantCredit();
    outCredit = 1'b1;
    granted++;
    @(negedge clk);
    outCredit = 1'b0;
  endtask

  task automatic waitResults(input int target, input string what);
    int cycles;
    cycles = 0;
    while (received < target && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (received < target) begin
      $display("%s: timed out with %0d of %0d results", what, received, target);
      errors++;
    end
  endtask

  // one credit held and an empty queue, so the latency is fixed.
  task automatic runOp(input logic [29:0] a, input logic [29:0] b, input logic sub);
    int cycles;
    grantCredit();
    sendBeat(a, b, sub);
    cycles = 1;
    while (!outValid && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    checkEq("latency from acceptance", 32'(cycles), 32'd3);
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    if (errors == errorsBefore) begin
      $display("test %s done, no errors", name);
    end else begin
      $display("test %s done, %0d errors", name, errors - errorsBefore);
    end
  endtask

  task automatic checkReset();
    int errorsBefore;
    errorsBefore = errors;
    checkEq("outValid after reset", 32'(outValid), 32'd0);
    checkEq("creditReturn after reset", 32'(creditReturn), 32'd0);
    sendBeat(30'h0000_7FFF, 30'h0000_0001, 1'b0);
    sendBeat(30'h2000_0000, 30'h0000_0010, 1'b1);
    repeat (10) begin
      @(negedge clk);
      checkEq("outValid without credits", 32'(outValid), 32'd0);
      checkEq("creditReturn without credits", 32'(creditReturn), 32'd0);
    end
    grantCredit();
    grantCredit();
    waitResults(sent, "reset drain");
    reportTest("reset", errorsBefore);
  endtask

  task automatic checkAddition();
    int errorsBefore;
    errorsBefore = errors;
    runOp(30'h0000_7FFF, 30'h0000_0001, 1'b0);  // carry into bit 16.
    runOp(30'h3FFF_FFFF, 30'h0000_0001, 1'b0);
    runOp(30'h1555_5555, 30'h2AAA_AAAB, 1'b0);
    runOp(30'h0000_4000, 30'h0000_4000, 1'b0);
    runOp(30'h1234_5678, 30'h0ABC_DEF0, 1'b0);
    waitResults(sent, "addition");
    reportTest("addition", errorsBefore);
  endtask

  task automatic checkSubtraction();
    int errorsBefore;
    errorsBefore = errors;
    runOp(30'h0000_8000, 30'h0000_0001, 1'b1);  // borrow across the halves.
    runOp(30'h0000_0005, 30'h0000_0007, 1'b1);
    runOp(30'h3FFF_FFFF, 30'h3FFF_FFFF, 1'b1);
    runOp(30'h1FFF_FFFF, 30'h0000_0001, 1'b0);  // largest positive plus one.
    runOp(30'h2000_0000, 30'h0000_0001, 1'b1);
    runOp(30'h2000_0000, 30'h2000_0000, 1'b0);
    runOp(30'h0000_0000, 30'h2000_0000, 1'b1);
    runOp(30'h1FFF_FFFF, 30'h3FFF_FFFF, 1'b1);
    waitResults(sent, "subtraction");
    reportTest("subtraction", errorsBefore);
  endtask

  task automatic checkBackPressure();
    int          errorsBefore;
    int          base;
    logic [31:0] ra;
    logic [31:0] rb;
    errorsBefore = errors;
    base         = received;
    checkEq("upstream credits before burst", 32'(upCredits), 32'(QueueDepth));
    for (int i = 0; i < int'(QueueDepth); i++) begin
      ra = $random(seed);
      rb = $random(seed);
      sendBeat(ra[29:0], rb[29:0], ra[31]);
    end
    checkEq("upstream credits after burst", 32'(upCredits), 32'd0);
    repeat (8) @(negedge clk);
    checkEq("results without credits", 32'(received), 32'(base));
    for (int i = 1; i <= int'(QueueDepth); i++) begin
      grantCredit();
      waitResults(base + i, "back-pressure");
      repeat (4) @(negedge clk);
      checkEq("results per credit", 32'(received), 32'(base + i));
    end
    reportTest("back-pressure", errorsBefore);
  endtask

  task automatic checkRandomStream();
    int          errorsBefore;
    int          count;
    int          cycles;
    logic [31:0] r;
    logic [31:0] ra;
    logic [31:0] rb;
    errorsBefore = errors;
    count        = 0;
    cycles       = 0;
    while ((count < RandomOps || received < sent) && cycles < RandomOps * 20) begin
      r         = $random(seed);
      outCredit = r[0] && (granted - received < int'(MaxCredits));  // stay under the limit.
      if (outCredit) begin
        granted++;
      end
      if (count < RandomOps && upCredits > 0 && r[1]) begin
        ra = $random(seed);
        rb = $random(seed);
        driveBeat(ra[29:0], rb[29:0], r[2]);
        count++;
      end else begin
        inValid = 1'b0;
      end
      @(negedge clk);
      cycles++;
    end
    outCredit = 1'b0;
    inValid   = 1'b0;
    if (count < RandomOps || received < sent) begin
      $display("random stream stalled, %0d sent and %0d received", sent, received);
      errors++;
    end
    repeat (3) @(negedge clk);
    checkEq("credit returns", 32'(returns), 32'(sent));
    reportTest("random stream", errorsBefore);
  endtask

  initial begin
    rstN      = 1'b0;
    inValid   = 1'b0;
    inA       = '0;
    inB       = '0;
    inSub     = 1'b0;
    outCredit = 1'b0;
    upCredits = int'(QueueDepth);
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    checkReset();
    checkAddition();
    checkSubtraction();
    checkBackPressure();
    checkRandomStream();
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
source/addPkg.sv
source/creditPkg.sv
source/cla15.sv
source/operandQueue.sv
source/lowHalfStage.sv
source/highHalfStage.sv
source/sumMerge.sv
source/adderStream.sv
tests/adderStreamTb.sv
